/* logic/dmm_macros.svh */
// dmm register map, field widths, mode codes and the status signature
`ifndef DMM_MACROS_SVH
`define DMM_MACROS_SVH

// frame is one address byte then one data word, msb first
`define DMM_REG_W           32
`define DMM_ADDR_W          8    // bit 7 of the address byte set means write

// register addresses
`define DMM_ADDR_SPI_MUX    8'h08
`define DMM_ADDR_4094       8'h09
`define DMM_ADDR_MODE       8'h0a
`define DMM_ADDR_DIRECT     8'h0b
`define DMM_ADDR_SEQ_MODE   8'h0c
`define DMM_ADDR_STATUS     8'h0d   // read only
`define DMM_ADDR_PRECHARGE  8'h10
`define DMM_ADDR_SEQ_N      8'h11
`define DMM_ADDR_SEQ0       8'h12
`define DMM_ADDR_SEQ1       8'h13
`define DMM_ADDR_SEQ2       8'h14
`define DMM_ADDR_SEQ3       8'h15
`define DMM_ADDR_APERTURE   8'h16

// output mode codes
`define DMM_MODE_DIRECT     3'd0
`define DMM_MODE_PATTERN    3'd3
`define DMM_MODE_SEQ        3'd6

`define DMM_STATUS_MAGIC    8'haa   // low byte of status
`define DMM_PATTERN_SHIFT   4       // counter bit that lands on output bit 0

`endif

/* logic/dmm_pkg.sv */
// dmm shared types for register words, board outputs and the sample sequencer
`include "dmm_macros.svh"

package dmm_pkg;

  typedef logic [`DMM_REG_W-1:0] reg_word_t;   // one spi register

  // board output vector, from bit 0 up
  //   leds 4, monitor 8, pc_sw 2, azmux 4,
  //   adc_refmux 4, cmpr_latch 1, spi_interrupt 1
  typedef logic [23:0] out_vec_t;

  typedef logic [5:0] seq_word_t;    // {pc_sw[1:0], azmux[3:0]}
  typedef logic [2:0] seq_idx_t;     // sample index and count
  typedef logic [23:0] clk_count_t;  // cycle counts, precharge and aperture
  typedef logic [2:0] mode_t;        // output mode code

  // sequencer fsm
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_PRECHARGE,
    SEQ_SAMPLE
  } seq_state_t;

endpackage

/* logic/spi_reg_bank.sv */
// spi register bank: oversampled spi slave with configuration registers and status readback
`include "dmm_macros.svh"

module spi_reg_bank (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                sck_i,
  input  logic                ss_i,
  input  logic                sdi_i,
  output logic                sdo_o,
  input  dmm_pkg::reg_word_t  status_i,
  output dmm_pkg::reg_word_t  spi_mux_o,
  output dmm_pkg::reg_word_t  oe_4094_o,
  output dmm_pkg::mode_t      mode_o,
  output dmm_pkg::reg_word_t  direct_o,
  output dmm_pkg::reg_word_t  seq_mode_o,
  output dmm_pkg::clk_count_t precharge_o,
  output dmm_pkg::seq_idx_t   seq_n_o,
  output dmm_pkg::seq_word_t  seq0_o,
  output dmm_pkg::seq_word_t  seq1_o,
  output dmm_pkg::seq_word_t  seq2_o,
  output dmm_pkg::seq_word_t  seq3_o,
  output dmm_pkg::clk_count_t aperture_o
);
  import dmm_pkg::*;

  localparam int FRAME_BITS = `DMM_ADDR_W + `DMM_REG_W;   // 40

  logic [2:0]            sck_q;       // 2 sync + 1 edge
  logic [2:0]            ss_q;
  logic [1:0]            sdi_q;
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  ss_rise;
  logic                  ss_high;
  logic [5:0]            bit_cnt_q;   // saturates, so long frames never commit
  logic [FRAME_BITS-1:0] rx_q;
  reg_word_t             tx_q;
  logic [`DMM_ADDR_W-1:0] rd_addr;
  logic [`DMM_ADDR_W-1:0] wr_addr;
  reg_word_t             rd_data;
  reg_word_t             wr_data;
  logic                  wr_en;

  //////////////////////////////
  // pin sync and edges

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign ss_rise  = ss_q[1] & ~ss_q[2];
  assign ss_high  = ss_q[1];           // frame idle

  assign sdo_o = tx_q[`DMM_REG_W-1];   // msb first

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sck_q     <= '0;
      ss_q      <= '1;   // idle high, no false release
      sdi_q     <= '0;
      bit_cnt_q <= '0;
      tx_q      <= '0;
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      ss_q  <= {ss_q[1:0], ss_i};
      sdi_q <= {sdi_q[0], sdi_i};
      if (ss_high) begin
        bit_cnt_q <= '0;
        tx_q      <= '0;
      end else begin
        if (sck_rise) begin
          if (bit_cnt_q != '1) bit_cnt_q <= bit_cnt_q + 6'd1;
          // address byte complete on this edge, load read data
          if (bit_cnt_q == 6'(`DMM_ADDR_W - 1)) tx_q <= rd_data;
        end
        // first data bit must survive the 8th falling edge
        if (sck_fall && bit_cnt_q > 6'(`DMM_ADDR_W)) begin
          tx_q <= {tx_q[`DMM_REG_W-2:0], 1'b0};
        end
      end
    end
  end

  // receive shift, payload only
  always_ff @(posedge clk) begin
    if (sck_rise && !ss_high) rx_q <= {rx_q[FRAME_BITS-2:0], sdi_q[1]};
  end

  //////////////////////////////
  // read mux

  // low 7 address bits as they complete, write flag masked
  assign rd_addr = {1'b0, rx_q[`DMM_ADDR_W-3:0], sdi_q[1]};

  always_comb begin
    case (rd_addr)
      `DMM_ADDR_SPI_MUX:   rd_data = spi_mux_o;
      `DMM_ADDR_4094:      rd_data = oe_4094_o;
      `DMM_ADDR_MODE:      rd_data = reg_word_t'(mode_o);
      `DMM_ADDR_DIRECT:    rd_data = direct_o;
      `DMM_ADDR_SEQ_MODE:  rd_data = seq_mode_o;
      `DMM_ADDR_STATUS:    rd_data = status_i;
      `DMM_ADDR_PRECHARGE: rd_data = reg_word_t'(precharge_o);
      `DMM_ADDR_SEQ_N:     rd_data = reg_word_t'(seq_n_o);
      `DMM_ADDR_SEQ0:      rd_data = reg_word_t'(seq0_o);
      `DMM_ADDR_SEQ1:      rd_data = reg_word_t'(seq1_o);
      `DMM_ADDR_SEQ2:      rd_data = reg_word_t'(seq2_o);
      `DMM_ADDR_SEQ3:      rd_data = reg_word_t'(seq3_o);
      `DMM_ADDR_APERTURE:  rd_data = reg_word_t'(aperture_o);
      default:             rd_data = '0;   // unknown reads zero
    endcase
  end

  //////////////////////////////
  // write commit on ss release

  assign wr_addr = {1'b0, rx_q[FRAME_BITS-2 -: `DMM_ADDR_W-1]};
  assign wr_data = rx_q[`DMM_REG_W-1:0];
  assign wr_en   = ss_rise && rx_q[FRAME_BITS-1] && (bit_cnt_q == 6'(FRAME_BITS));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      spi_mux_o   <= '0;   // all buses parked
      oe_4094_o   <= '0;   // 4094 outputs off at start
      mode_o      <= '0;
      direct_o    <= '0;
      seq_mode_o  <= '0;
      precharge_o <= '0;
      seq_n_o     <= '0;
      seq0_o      <= '0;
      seq1_o      <= '0;
      seq2_o      <= '0;
      seq3_o      <= '0;
      aperture_o  <= '0;
    end else if (wr_en) begin
      case (wr_addr)
        `DMM_ADDR_SPI_MUX:   spi_mux_o   <= wr_data;
        `DMM_ADDR_4094:      oe_4094_o   <= wr_data;
        `DMM_ADDR_MODE:      mode_o      <= wr_data[$bits(mode_t)-1:0];
        `DMM_ADDR_DIRECT:    direct_o    <= wr_data;
        `DMM_ADDR_SEQ_MODE:  seq_mode_o  <= wr_data;
        `DMM_ADDR_PRECHARGE: precharge_o <= wr_data[$bits(clk_count_t)-1:0];
        `DMM_ADDR_SEQ_N:     seq_n_o     <= wr_data[$bits(seq_idx_t)-1:0];
        `DMM_ADDR_SEQ0:      seq0_o      <= wr_data[$bits(seq_word_t)-1:0];
        `DMM_ADDR_SEQ1:      seq1_o      <= wr_data[$bits(seq_word_t)-1:0];
        `DMM_ADDR_SEQ2:      seq2_o      <= wr_data[$bits(seq_word_t)-1:0];
        `DMM_ADDR_SEQ3:      seq3_o      <= wr_data[$bits(seq_word_t)-1:0];
        `DMM_ADDR_APERTURE:  aperture_o  <= wr_data[$bits(clk_count_t)-1:0];
        default: ;   // status is read only
      endcase
    end
  end

endmodule

/* logic/spi_cs_router.sv */
// spi chip-select router: lends the shared spi lines to the 4094 or one of the dacs
module spi_cs_router (
  input  logic               sck_i,
  input  logic               sdi_i,
  input  logic               cs2_i,
  input  dmm_pkg::reg_word_t spi_mux_i,
  output logic               glb_clk_o,
  output logic               glb_mosi_o,
  output logic               strobe_4094_o,
  output logic               dac_ss_o,
  output logic               iso_dac_cs_o,
  output logic               iso_dac_cs2_o
);
  import dmm_pkg::*;

  // one-hot peripheral codes
  localparam reg_word_t MUX_4094    = reg_word_t'(1);
  localparam reg_word_t MUX_DAC     = reg_word_t'(2);
  localparam reg_word_t MUX_ISO_DAC = reg_word_t'(4);
  localparam reg_word_t MUX_ISO_DAC2 = reg_word_t'(8);

  assign glb_clk_o  = (spi_mux_i == '0) ? 1'b1 : sck_i;   // park hi
  assign glb_mosi_o = (spi_mux_i == '0) ? 1'b1 : sdi_i;   // park hi

  assign strobe_4094_o = (spi_mux_i == MUX_4094) ? ~cs2_i : 1'b0;     // active hi
  assign dac_ss_o      = (spi_mux_i == MUX_DAC) ? cs2_i : 1'b1;       // active lo
  assign iso_dac_cs_o  = (spi_mux_i == MUX_ISO_DAC) ? cs2_i : 1'b1;   // active lo
  assign iso_dac_cs2_o = (spi_mux_i == MUX_ISO_DAC2) ? cs2_i : 1'b1;  // active lo

endmodule

/* logic/sample_seq.sv */
// sample sequencer: steps precharge and azero switches and paces the adc reset
module sample_seq (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                trig_i,
  input  logic                adc_valid_i,
  input  dmm_pkg::clk_count_t precharge_i,
  input  dmm_pkg::seq_idx_t   seq_n_i,
  input  dmm_pkg::seq_word_t  seq0_i,
  input  dmm_pkg::seq_word_t  seq1_i,
  input  dmm_pkg::seq_word_t  seq2_i,
  input  dmm_pkg::seq_word_t  seq3_i,
  output logic [1:0]          pc_sw_o,
  output logic [3:0]          azmux_o,
  output logic [3:0]          leds_o,
  output logic [7:0]          monitor_o,
  output logic                adc_reset_n_o,
  output dmm_pkg::seq_idx_t   sample_idx_last_o
);
  import dmm_pkg::*;

  logic [1:0] trig_q;       // two flop sync
  seq_state_t state_q;
  seq_idx_t   idx_q;
  seq_idx_t   idx_next;
  seq_idx_t   n_eff;        // number of steps, 1 to 4
  clk_count_t cnt_q;        // precharge down count
  clk_count_t pc_load;
  seq_word_t  step;
  logic       active;

  //////////////////////////////
  // step bookkeeping

  always_comb begin
    if (seq_n_i == '0) begin
      n_eff = seq_idx_t'(1);          // 0 acts as 1
    end else if (seq_n_i > seq_idx_t'(4)) begin
      n_eff = seq_idx_t'(4);          // only four step words
    end else begin
      n_eff = seq_n_i;
    end
  end

  assign idx_next = (idx_q + seq_idx_t'(1) >= n_eff) ? '0 : idx_q + seq_idx_t'(1);
  assign pc_load  = (precharge_i == '0) ? clk_count_t'(1) : precharge_i;   // min 1

  always_comb begin
    case (idx_q[1:0])
      2'd0: step = seq0_i;
      2'd1: step = seq1_i;
      2'd2: step = seq2_i;
      default: step = seq3_i;
    endcase
  end

  //////////////////////////////
  // outputs, straight off state

  assign active        = (state_q != SEQ_IDLE);
  assign pc_sw_o       = active ? step[5:4] : 2'b00;
  assign azmux_o       = active ? step[3:0] : 4'b0000;
  assign leds_o        = active ? (4'b0001 << idx_q[1:0]) : 4'b0000;   // one-hot idx
  assign adc_reset_n_o = (state_q == SEQ_SAMPLE);    // adc runs only while sampling
  assign monitor_o     = {2'b00, idx_q, adc_valid_i,
                          state_q == SEQ_SAMPLE, state_q == SEQ_PRECHARGE};

  //////////////////////////////
  // fsm

  always_ff @(posedge clk) begin
    if (rst_i) begin
      trig_q            <= '0;
      state_q           <= SEQ_IDLE;
      idx_q             <= '0;
      cnt_q             <= '0;
      sample_idx_last_o <= '0;
    end else begin
      trig_q <= {trig_q[0], trig_i};
      if (!trig_q[1]) begin
        state_q <= SEQ_IDLE;       // trigger low holds us parked
        idx_q   <= '0;
        cnt_q   <= '0;
      end else begin
        case (state_q)
          SEQ_IDLE: begin
            state_q <= SEQ_PRECHARGE;
            cnt_q   <= pc_load;
          end
          SEQ_PRECHARGE: begin
            if (cnt_q <= clk_count_t'(1)) begin
              state_q <= SEQ_SAMPLE;   // last precharge cycle
            end else begin
              cnt_q <= cnt_q - clk_count_t'(1);
            end
          end
          SEQ_SAMPLE: begin
            if (adc_valid_i) begin
              sample_idx_last_o <= idx_q;   // for status readback
              idx_q             <= idx_next;
              state_q           <= SEQ_PRECHARGE;
              cnt_q             <= pc_load;
            end
          end
          default: state_q <= SEQ_IDLE;
        endcase
      end
    end
  end

endmodule

/* logic/adc_mock.sv */
// mock adc: counts the aperture after reset release and flags one valid sample
module adc_mock (
  input  logic                clk,
  input  logic                reset_n_i,
  input  dmm_pkg::clk_count_t aperture_i,
  output logic                valid_o
);
  import dmm_pkg::*;

  clk_count_t cnt_q;
  clk_count_t ap_eff;
  logic       done_q;   // one pulse per reset release

  assign ap_eff = (aperture_i == '0) ? clk_count_t'(1) : aperture_i;

  // reset_n from the sequencer is the only reset here
  always_ff @(posedge clk) begin
    if (!reset_n_i) begin
      cnt_q   <= '0;
      done_q  <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= 1'b0;   // single cycle
      if (!done_q) begin
        cnt_q <= cnt_q + clk_count_t'(1);
        if (cnt_q == ap_eff - clk_count_t'(1)) begin
          valid_o <= 1'b1;   // aperture cycles after release
          done_q  <= 1'b1;   // wait for next reset
        end
      end
    end
  end

endmodule

/* logic/mode_mux.sv */
// output mode mux: selects direct register, test pattern or sequencer onto the board vector
`include "dmm_macros.svh"

module mode_mux (
  input  logic               clk,
  input  logic               rst_i,
  input  dmm_pkg::mode_t     mode_i,
  input  dmm_pkg::reg_word_t direct_i,
  input  logic [1:0]         pc_sw_i,
  input  logic [3:0]         azmux_i,
  input  logic [3:0]         leds_i,
  input  logic [7:0]         monitor_i,
  output dmm_pkg::out_vec_t  out_o
);
  import dmm_pkg::*;

  localparam int OUT_W = $bits(out_vec_t);

  logic [OUT_W+`DMM_PATTERN_SHIFT-1:0] pat_q;   // free running
  out_vec_t pattern;
  out_vec_t seq_vec;

  always_ff @(posedge clk) begin
    if (rst_i) pat_q <= '0;
    else pat_q <= pat_q + 1'b1;
  end

  // slow enough to watch on a scope, bit 0 toggles every 16 clk
  assign pattern = pat_q[`DMM_PATTERN_SHIFT +: OUT_W];

  assign seq_vec = {
    1'b0,        // spi_interrupt
    1'b0,        // cmpr_latch
    4'b0000,     // adc_refmux
    azmux_i,
    pc_sw_i,
    monitor_i,
    leds_i
  };

  always_comb begin
    case (mode_i)
      `DMM_MODE_DIRECT:  out_o = direct_i[OUT_W-1:0];
      `DMM_MODE_PATTERN: out_o = pattern;
      `DMM_MODE_SEQ:     out_o = seq_vec;
      default:           out_o = '0;   // other codes park everything low
    endcase
  end

endmodule

/* logic/dmm_top.sv */
// dmm fpga top: spi register bank, spi bus routing, sample sequencer and output mode select
`include "dmm_macros.svh"

module dmm_top (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       sck_i,
  input  logic       sdi_i,
  input  logic       ss_i,
  input  logic       cs2_i,
  input  logic [3:0] hw_flags_i,
  input  logic       trig_sa_i,
  input  logic       adc_cmpr_p_i,   // comparator, no adc here yet
  output logic       sdo_o,
  output logic       glb_clk_o,
  output logic       glb_mosi_o,
  output logic       strobe_4094_o,
  output logic       dac_ss_o,
  output logic       iso_dac_cs_o,
  output logic       iso_dac_cs2_o,
  output logic       spi_4094_oe_o,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic [3:0] adc_refmux_o,
  output logic       adc_cmpr_latch_ctl_o,
  output logic       spi_interrupt_o,
  output logic       unused3_o
);
  import dmm_pkg::*;

  reg_word_t  spi_mux, oe_4094, direct, seq_mode, status;
  mode_t      mode;
  clk_count_t precharge, aperture;
  seq_idx_t   seq_n, sample_idx_last;
  seq_word_t  seq0, seq1, seq2, seq3;
  logic [1:0] seq_pc_sw;
  logic [3:0] seq_azmux, seq_leds;
  logic [7:0] seq_monitor;
  logic       adc_reset_n, adc_valid;
  out_vec_t   out_vec;

  assign unused3_o     = 1'b1;         // keeps the isolator input from floating
  assign spi_4094_oe_o = oe_4094[0];   // lo at power up

  // status word, top byte first
  assign status = {4'b0000, seq_mode[3:0],
                   1'b0, seq_n, 1'b0, sample_idx_last,
                   spi_mux[3:0], hw_flags_i,
                   `DMM_STATUS_MAGIC};

  spi_reg_bank u_regs (
    .clk, .rst_i, .sck_i, .ss_i, .sdi_i, .sdo_o,
    .status_i(status), .spi_mux_o(spi_mux), .oe_4094_o(oe_4094), .mode_o(mode),
    .direct_o(direct), .seq_mode_o(seq_mode), .precharge_o(precharge), .seq_n_o(seq_n),
    .seq0_o(seq0), .seq1_o(seq1), .seq2_o(seq2), .seq3_o(seq3), .aperture_o(aperture)
  );

  spi_cs_router u_router (
    .sck_i, .sdi_i, .cs2_i, .spi_mux_i(spi_mux),
    .glb_clk_o, .glb_mosi_o, .strobe_4094_o, .dac_ss_o, .iso_dac_cs_o, .iso_dac_cs2_o
  );

  sample_seq u_seq (
    .clk, .rst_i, .trig_i(trig_sa_i), .adc_valid_i(adc_valid),
    .precharge_i(precharge), .seq_n_i(seq_n),
    .seq0_i(seq0), .seq1_i(seq1), .seq2_i(seq2), .seq3_i(seq3),
    .pc_sw_o(seq_pc_sw), .azmux_o(seq_azmux), .leds_o(seq_leds), .monitor_o(seq_monitor),
    .adc_reset_n_o(adc_reset_n), .sample_idx_last_o(sample_idx_last)
  );

  adc_mock u_adc (.clk, .reset_n_i(adc_reset_n), .aperture_i(aperture), .valid_o(adc_valid));

  mode_mux u_mode (
    .clk, .rst_i, .mode_i(mode), .direct_i(direct),
    .pc_sw_i(seq_pc_sw), .azmux_i(seq_azmux), .leds_i(seq_leds), .monitor_i(seq_monitor),
    .out_o(out_vec)
  );

  // unpack in out_vec_t order, msb first
  assign {spi_interrupt_o, adc_cmpr_latch_ctl_o, adc_refmux_o,
          azmux_o, pc_sw_o, monitor_o, leds_o} = out_vec;

endmodule

/* sim/dmm_checker.sv */
// dmm checker: reset, chip-select and mode assertions bound onto the top level
`include "dmm_macros.svh"

module dmm_checker (
  input logic           clk,
  input logic           rst_i,
  input dmm_pkg::mode_t mode_i,
  input logic [23:0]    out_i,        // board vector, out_vec_t order
  input logic           oe_i,
  input logic [2:0]     dac_sel_n_i   // active low selects
);
  import dmm_pkg::*;

  // registers reset on the first edge, so check from the cycle after
  reset_outputs_low: assert property (@(posedge clk)
    $past(rst_i) |-> (out_i == '0 && !oe_i))
    else $error("control outputs not low during reset");

  one_dac_select: assert property (@(posedge clk) disable iff (rst_i)
    $onehot0(~dac_sel_n_i))
    else $error("more than one dac select active");

  bad_mode_parks: assert property (@(posedge clk) disable iff (rst_i)
    !(mode_i inside {`DMM_MODE_DIRECT, `DMM_MODE_PATTERN, `DMM_MODE_SEQ}) |-> out_i == '0)
    else $error("outputs driven in an unused mode");

endmodule

bind dmm_top dmm_checker u_checker (
  .clk(clk), .rst_i(rst_i), .mode_i(mode),
  .out_i({spi_interrupt_o, adc_cmpr_latch_ctl_o, adc_refmux_o, azmux_o, pc_sw_o,
          monitor_o, leds_o}),
  .oe_i(spi_4094_oe_o),
  .dac_sel_n_i({dac_ss_o, iso_dac_cs_o, iso_dac_cs2_o})
);

/* sim/dmm_tb.sv */
// dmm testbench: spi master, pattern-file playback and output checks on the top level
module dmm_tb;
  logic clk, rst_i, sck_i, sdi_i, ss_i, cs2_i, trig_sa_i, adc_cmpr_p_i;
  logic [3:0] hw_flags_i;
  logic sdo_o, glb_clk_o, glb_mosi_o, strobe_4094_o, dac_ss_o, iso_dac_cs_o, iso_dac_cs2_o;
  logic spi_4094_oe_o, adc_cmpr_latch_ctl_o, spi_interrupt_o, unused3_o;
  logic [3:0] leds_o, azmux_o, adc_refmux_o;
  logic [7:0] monitor_o;
  logic [1:0] pc_sw_o;

  logic [31:0] pats [0:255];     // 4 words per record
  logic [31:0] shadow [0:255];   // last written value per address
  int mismatches = 0;
  int timeouts = 0;
  logic timed_out = 1'b0;

  dmm_top u_dmm_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // hard stop, independent of the per-wait limits
  initial begin
    #3000000;
    $display("run limit reached before the pattern file finished");
    $display("STATUS: FAIL");
    $finish;
  end

  //////////////////////////////
  // helpers

  task automatic clk_wait(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp, act);
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
    mismatches++;
  endtask

  function automatic logic [23:0] observed_vec();
    return {spi_interrupt_o, adc_cmpr_latch_ctl_o, adc_refmux_o, azmux_o, pc_sw_o,
            monitor_o, leds_o};   // out_vec_t layout
  endfunction

  // one 40-bit frame, mode 0, msb first; random sck gaps
  task automatic spi_frame(input logic [7:0] addr, input logic [31:0] data,
                           output logic [31:0] rd);
    logic [39:0] frame;
    frame = {addr, data};
    rd = '0;
    ss_i = 1'b0;
    clk_wait(4 + ($urandom % 4));
    for (int i = 39; i >= 0; i--) begin
      sdi_i = frame[i];
      clk_wait(4 + ($urandom % 4));
      if (i < 32) rd[i] = sdo_o;   // sampled just before the rising edge
      sck_i = 1'b1;
      clk_wait(4 + ($urandom % 4));
      sck_i = 1'b0;
    end
    clk_wait(4 + ($urandom % 4));
    ss_i = 1'b1;                   // commit
    clk_wait(6);                   // write lands within 4 cycles
  endtask

  task automatic wait_monitor(input int bit_n, input logic level, input string what,
                              output logic ok);
    ok = 1'b0;
    for (int n = 0; n < 500; n++) begin
      if (monitor_o[bit_n] == level) begin
        ok = 1'b1;
        break;
      end
      @(negedge clk);
    end
    if (!ok) begin
      $display("timed out waiting for %s", what);
      timeouts++;
      timed_out = 1'b1;
    end
  endtask

  //////////////////////////////
  // behavior checks

  task automatic check_route(input logic [31:0] mux);
    logic [31:0] rd;
    logic [3:0] exp;
    spi_frame(8'h88, mux, rd);
    shadow[8'h08] = mux;
    cs2_i = 1'b1;
    clk_wait(1);
    assert ({strobe_4094_o, dac_ss_o, iso_dac_cs_o, iso_dac_cs2_o} == 4'b0111)
      else report_mismatch($sformatf("route %0d cs2 high", mux), 4'b0111,
                           {strobe_4094_o, dac_ss_o, iso_dac_cs_o, iso_dac_cs2_o});
    cs2_i = 1'b0;
    clk_wait(1);
    exp = {mux == 1, mux != 2, mux != 4, mux != 8};   // only the selected one moves
    assert ({strobe_4094_o, dac_ss_o, iso_dac_cs_o, iso_dac_cs2_o} == exp)
      else report_mismatch($sformatf("route %0d cs2 low", mux), exp,
                           {strobe_4094_o, dac_ss_o, iso_dac_cs_o, iso_dac_cs2_o});
    if (mux == 0) begin
      assert ({glb_clk_o, glb_mosi_o} == 2'b11)
        else report_mismatch("route parked lines", 2'b11, {glb_clk_o, glb_mosi_o});
    end else begin
      // shared lines follow the master pins
      assert ({glb_clk_o, glb_mosi_o} == {sck_i, sdi_i})
        else report_mismatch($sformatf("route %0d shared lines", mux), {sck_i, sdi_i},
                             {glb_clk_o, glb_mosi_o});
    end
    cs2_i = 1'b1;
  endtask

  task automatic check_pattern(input int samples);
    logic [23:0] a, b;
    for (int k = 0; k < samples; k++) begin
      a = observed_vec();
      clk_wait(16);
      b = observed_vec();
      assert (b == a + 24'd1) else report_mismatch("pattern step", a + 24'd1, b);
    end
  endtask

  task automatic run_sequence(input int samples);
    logic ok;
    logic [5:0] exp_step;
    logic [31:0] rd;
    logic [2:0] exp_last;
    int n_steps, len, exp_len;
    n_steps = (shadow[8'h11] == 0) ? 1 : int'(shadow[8'h11]);
    exp_len = (shadow[8'h10] == 0) ? 1 : int'(shadow[8'h10]);   // at least one cycle
    trig_sa_i = 1'b1;
    for (int k = 0; k < samples; k++) begin
      wait_monitor(0, 1'b1, "precharge start", ok);
      if (!ok) return;
      exp_step = shadow[8'h12 + (k % n_steps)][5:0];
      len = 0;
      while (monitor_o[0] && len < 1000) begin
        assert ({pc_sw_o, azmux_o} == exp_step)
          else report_mismatch($sformatf("seq step %0d", k), exp_step, {pc_sw_o, azmux_o});
        len++;
        @(negedge clk);
      end
      assert (len == exp_len)
        else report_mismatch($sformatf("precharge len %0d", k), exp_len, len);
    end
    wait_monitor(0, 1'b1, "last sample done", ok);   // next precharge ends the sample
    if (!ok) return;
    trig_sa_i = 1'b0;
    wait_monitor(0, 1'b0, "sequencer idle", ok);
    if (!ok) return;
    spi_frame(8'h0d, '0, rd);
    exp_last = 3'((samples - 1) % n_steps);
    assert (rd[18:16] == exp_last)
      else report_mismatch("sample_idx_last", exp_last, rd[18:16]);
  endtask

  //////////////////////////////
  // main playback

  initial begin
    logic [31:0] rd;
    logic [7:0] addr;
    int r;
    rst_i = 1'b1;
    sck_i = 1'b0;
    sdi_i = 1'b0;
    ss_i = 1'b1;
    cs2_i = 1'b1;          // selects idle
    trig_sa_i = 1'b0;
    adc_cmpr_p_i = 1'b0;
    hw_flags_i = 4'h5;
    void'($urandom(32'hc86b));
    $readmemh("sim/dmm_patterns.mem", pats);
    clk_wait(2);
    rst_i = 1'b0;
    clk_wait(4);
    r = 0;
    while (r < 64 && pats[4*r] != 0 && !timed_out) begin
      addr = pats[4*r+1][7:0];
      case (pats[4*r])
        1: begin
          spi_frame({1'b1, addr[6:0]}, pats[4*r+2], rd);
          if (addr != 8'h0d) shadow[addr] = pats[4*r+2];
        end
        2: begin
          spi_frame({1'b0, addr[6:0]}, '0, rd);
          assert (rd == pats[4*r+3])
            else report_mismatch($sformatf("read %h", addr), pats[4*r+3], rd);
        end
        3: begin
          assert (observed_vec() == pats[4*r+3][23:0])
            else report_mismatch("output vector", pats[4*r+3], observed_vec());
          // 4094 enable is bit 0 of its register
          assert (spi_4094_oe_o == shadow[8'h09][0])
            else report_mismatch("4094 output enable", shadow[8'h09][0], spi_4094_oe_o);
          assert (unused3_o == 1'b1)
            else report_mismatch("unused3 tie high", 1'b1, unused3_o);
        end
        4: run_sequence(int'(pats[4*r+2]));
        5: check_route(pats[4*r+2]);
        6: check_pattern(int'(pats[4*r+2]));
        default: begin
          $display("pattern record %0d has an unknown opcode", r);
          mismatches++;
        end
      endcase
      r++;
    end
    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+logic
logic/dmm_pkg.sv
logic/spi_reg_bank.sv
logic/spi_cs_router.sv
logic/sample_seq.sv
logic/adc_mock.sv
logic/mode_mux.sv
logic/dmm_top.sv
sim/dmm_checker.sv
sim/dmm_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := dmm_tb
FLIST     := vlog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN) sim/dmm_patterns.mem
	./$(BIN) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/dmm_patterns.mem */
// record: opcode addr data expected, one record per line
// opcode 1 write, 2 read-compare, 3 output-compare, 4 sequence-run, 5 route, 6 pattern, 0 end
01 08 00000002 00000000
02 08 00000000 00000002
01 09 00000001 00000000
02 09 00000000 00000001
01 0c 0000000b 00000000
02 0c 00000000 0000000b
01 10 00000005 00000000
02 10 00000000 00000005
01 11 00000003 00000000
02 11 00000000 00000003
01 12 00000021 00000000
02 12 00000000 00000021
01 13 00000012 00000000
02 13 00000000 00000012
01 14 00000034 00000000
02 14 00000000 00000034
01 15 0000000f 00000000
02 15 00000000 0000000f
01 16 00000009 00000000
02 16 00000000 00000009
01 0b 00a5c3f1 00000000
02 0b 00000000 00a5c3f1
03 00 00000000 00a5c3f1
02 0d 00000000 0b3025aa
01 0d ffffffff 00000000
02 0d 00000000 0b3025aa
02 7f 00000000 00000000
01 0a 00000005 00000000
02 0a 00000000 00000005
03 00 00000000 00000000
01 0a 00000000 00000000
01 0b 00123456 00000000
03 00 00000000 00123456
05 00 00000000 00000000
05 00 00000001 00000000
05 00 00000002 00000000
05 00 00000004 00000000
05 00 00000008 00000000
01 0a 00000003 00000000
06 00 00000004 00000000
01 0a 00000006 00000000
04 00 00000004 00000000
00 00 00000000 00000000
